/* Bender.yml */
package:
  name: wisc_core

sources:
  - hdl/wisc_pkg.sv
  - hdl/instr_decoder.sv
  - hdl/apb_prog_port.sv
  - hdl/core_datapath.sv
  - hdl/wisc_top.sv
  - target: test
    files:
      - verif/wisc_checker.sv
      - verif/wisc_sva.sv
      - verif/tb_wisc.sv

/* flist.f */
hdl/wisc_pkg.sv
hdl/instr_decoder.sv
hdl/apb_prog_port.sv
hdl/core_datapath.sv
hdl/wisc_top.sv
verif/wisc_checker.sv
verif/wisc_sva.sv
verif/tb_wisc.sv

/* hdl/apb_prog_port.sv */
`timescale 1ns/1ps

module apb_prog_port #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [9:0]                            paddr,
    input  logic [wisc_pkg::DATA_W-1:0]           pwdata,
    output logic [wisc_pkg::DATA_W-1:0]           prdata,
    output logic                                  pready,
    output logic                                  pslverr,
    input  logic [$clog2(IMEM_DEPTH)-1:0]         fetch_addr,
    output logic [wisc_pkg::DATA_W-1:0]           instr,
    output logic                                  start,
    output logic [$clog2(wisc_pkg::NUM_REGS)-1:0] dbg_addr,
    input  logic [wisc_pkg::DATA_W-1:0]           dbg_data,
    input  logic                                  running,
    input  logic                                  halted,
    input  logic                                  error,
    input  logic [$clog2(IMEM_DEPTH)-1:0]         pc
);
    import wisc_pkg::*;

    localparam int PC_W = $clog2(IMEM_DEPTH);

    logic [DATA_W-1:0] imem [IMEM_DEPTH];
    logic [1:0]        region;
    logic [7:0]        offset;
    logic              access;
    logic              acc_err;
    logic              slow_rd;   // registered read, one wait state
    logic              rd_pend;
    logic [DATA_W-1:0] rd_q;

    assign region   = paddr[9:8];
    assign offset   = paddr[7:0];
    assign access   = psel & penable;
    assign dbg_addr = offset[$clog2(NUM_REGS)-1:0];
    assign instr    = imem[fetch_addr];

    always_comb begin
        case (region)
            REGION_IMEM: acc_err = (int'(offset) >= IMEM_DEPTH) | (pwrite & running);
            REGION_CSR:  acc_err = (offset > CSR_PC) | (pwrite & (offset != CSR_CTRL));
            REGION_REGS: acc_err = (int'(offset) >= NUM_REGS) | pwrite;
            default:     acc_err = 1'b1;
        endcase
    end

    assign slow_rd = ~pwrite & ~acc_err & (region != REGION_IMEM);
    assign pready  = ~slow_rd | rd_pend;
    assign pslverr = access & acc_err;
    assign prdata  = rd_pend ? rd_q : imem[offset[PC_W-1:0]];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_pend <= 1'b0;
            start   <= 1'b0;
        end else begin
            rd_pend <= access & slow_rd & ~rd_pend;
            start   <= access & pwrite & ~acc_err & (region == REGION_CSR) & pwdata[0];
        end
    end

    always_ff @(posedge clk) begin
        if (access & slow_rd & ~rd_pend) begin
            if (region == REGION_REGS)
                rd_q <= dbg_data;
            else if (offset == CSR_STATUS)
                rd_q <= {{(DATA_W-3){1'b0}}, error, halted, running};
            else if (offset == CSR_PC)
                rd_q <= {{(DATA_W-PC_W){1'b0}}, pc};
            else
                rd_q <= '0;   // ctrl reads as zero
        end
        if (access & pwrite & ~acc_err & (region == REGION_IMEM))
            imem[offset[PC_W-1:0]] <= pwdata;
    end

endmodule

/* hdl/core_datapath.sv */
`timescale 1ns/1ps

module core_datapath #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [wisc_pkg::DATA_W-1:0]           instr,
    input  logic                                  start,
    input  logic [$clog2(wisc_pkg::NUM_REGS)-1:0] dbg_addr,
    input  wisc_pkg::ctrl_t                       ctrl,
    output logic [$clog2(IMEM_DEPTH)-1:0]         fetch_addr,
    output wisc_pkg::opcode_e                     opcode,
    output logic [1:0]                            func,
    output logic [wisc_pkg::DATA_W-1:0]           dbg_data,
    output logic                                  running,
    output logic                                  halted,
    output logic                                  error,
    output logic [$clog2(IMEM_DEPTH)-1:0]         pc
);
    import wisc_pkg::*;

    localparam int PC_W = $clog2(IMEM_DEPTH);
    localparam int RA_W = $clog2(NUM_REGS);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic [RA_W-1:0]   rs_addr;
    logic [RA_W-1:0]   rt_addr;
    logic [RA_W-1:0]   wr_addr;
    logic [DATA_W-1:0] imm;
    logic [DATA_W-1:0] op_a;
    logic [DATA_W-1:0] op_b;
    logic [DATA_W-1:0] alu_res;
    logic              wr_en;
    logic              br_taken;
    logic [PC_W-1:0]   pc_inc;
    logic [PC_W-1:0]   pc_next;

    assign opcode     = opcode_e'(instr[15:11]);
    assign func       = instr[1:0];
    assign rs_addr    = instr[10:8];
    assign rt_addr    = instr[7:5];
    assign fetch_addr = pc;
    assign dbg_data   = regs[dbg_addr];

    always_comb begin
        case (ctrl.reg_dst)
            RD_R:    wr_addr = instr[4:2];
            RS:      wr_addr = instr[10:8];
            default: wr_addr = instr[7:5];
        endcase
        case (ctrl.imm_sel)
            SEXT5:   imm = {{11{instr[4]}}, instr[4:0]};
            SEXT8:   imm = {{8{instr[7]}}, instr[7:0]};
            SEXT11:  imm = {{5{instr[10]}}, instr[10:0]};
            default: imm = {11'd0, instr[4:0]};
        endcase
    end

    assign op_a = regs[rs_addr];
    assign op_b = ctrl.alu_src_imm ? imm : regs[rt_addr];

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:        alu_res = op_a + op_b;
            ALU_SUB_REV:    alu_res = op_b - op_a;
            ALU_XOR:        alu_res = op_a ^ op_b;
            ALU_ANDN:       alu_res = op_a & ~op_b;
            ALU_EQ:         alu_res = {15'd0, op_a == op_b};
            ALU_LT:         alu_res = {15'd0, $signed(op_a) < $signed(op_b)};
            ALU_LE:         alu_res = {15'd0, $signed(op_a) <= $signed(op_b)};
            ALU_PASS_B:     alu_res = op_b;
            ALU_SHIFT_LOAD: alu_res = {op_a[7:0], op_b[7:0]};
            default:        alu_res = '0;
        endcase
    end

    // condition from sign and zero test of rs
    assign br_taken = ctrl.branch & ((ctrl.br_eqz & (op_a == '0)) |
                                     (ctrl.br_ltz & op_a[DATA_W-1]) |
                                     (ctrl.br_gtz & ~op_a[DATA_W-1] & (op_a != '0)));

    assign pc_inc  = pc + 1'b1;   // wraps at imem depth
    assign pc_next = (br_taken | ctrl.jump) ? pc_inc + imm[PC_W-1:0] : pc_inc;
    assign wr_en   = running & ~start & ctrl.reg_write;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= '0;
            running <= 1'b0;
            halted  <= 1'b0;
            error   <= 1'b0;
        end else if (start) begin
            pc      <= '0;
            running <= 1'b1;
            halted  <= 1'b0;
            error   <= 1'b0;
        end else if (running) begin
            if (ctrl.err) begin
                error   <= 1'b1;   // pc stays on the bad instruction
                running <= 1'b0;
            end else if (ctrl.halt) begin
                halted  <= 1'b1;
                running <= 1'b0;
            end else begin
                pc <= pc_next;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[wr_addr] <= alu_res;
        end
    end

endmodule

/* hdl/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  wisc_pkg::opcode_e opcode,
    input  logic [1:0]        func,
    output wisc_pkg::ctrl_t   ctrl
);
    import wisc_pkg::*;

    always_comb begin
        ctrl.reg_write   = 1'b0;
        ctrl.reg_dst     = RD_I1;
        ctrl.imm_sel     = ZEXT5;
        ctrl.alu_src_imm = 1'b0;
        ctrl.alu_op      = ALU_ADD;
        ctrl.branch      = 1'b0;
        ctrl.br_eqz      = 1'b0;
        ctrl.br_gtz      = 1'b0;
        ctrl.br_ltz      = 1'b0;
        ctrl.jump        = 1'b0;
        ctrl.halt        = 1'b0;
        ctrl.err         = 1'b0;

        case (opcode)
            OP_HALT: begin
                ctrl.halt = 1'b1;
            end

            OP_NOP, OP_SIIC: begin   // siic behaves as nop
            end

            OP_ADDI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.imm_sel     = SEXT5;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_ADD;
            end

            OP_SUBI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.imm_sel     = SEXT5;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_SUB_REV;   // imm - rs
            end

            OP_XORI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_XOR;
            end

            OP_ANDNI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_ANDN;
            end

            OP_ALU: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = RD_R;
                case (func)
                    2'b00:   ctrl.alu_op = ALU_ADD;
                    2'b01:   ctrl.alu_op = ALU_SUB_REV;   // rt - rs
                    2'b10:   ctrl.alu_op = ALU_XOR;
                    default: ctrl.alu_op = ALU_ANDN;
                endcase
            end

            OP_SEQ: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = RD_R;
                ctrl.alu_op    = ALU_EQ;
            end

            OP_SLT: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = RD_R;
                ctrl.alu_op    = ALU_LT;
            end

            OP_SLE: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = RD_R;
                ctrl.alu_op    = ALU_LE;
            end

            OP_BEQZ: begin
                ctrl.imm_sel = SEXT8;
                ctrl.branch  = 1'b1;
                ctrl.br_eqz  = 1'b1;
            end

            OP_BNEZ: begin
                ctrl.imm_sel = SEXT8;
                ctrl.branch  = 1'b1;
                ctrl.br_gtz  = 1'b1;
                ctrl.br_ltz  = 1'b1;
            end

            OP_BLTZ: begin
                ctrl.imm_sel = SEXT8;
                ctrl.branch  = 1'b1;
                ctrl.br_ltz  = 1'b1;
            end

            OP_BGEZ: begin
                ctrl.imm_sel = SEXT8;
                ctrl.branch  = 1'b1;
                ctrl.br_eqz  = 1'b1;
                ctrl.br_gtz  = 1'b1;
            end

            OP_LBI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.reg_dst     = RS;
                ctrl.imm_sel     = SEXT8;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_PASS_B;
            end

            OP_SLBI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.reg_dst     = RS;
                ctrl.imm_sel     = SEXT8;   // alu keeps only the low byte
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_SHIFT_LOAD;
            end

            OP_J: begin
                ctrl.imm_sel = SEXT11;
                ctrl.jump    = 1'b1;
            end

            default: ctrl.err = 1'b1;
        endcase
    end

endmodule

/* hdl/wisc_pkg.sv */
package wisc_pkg;

    localparam int DATA_W   = 16;
    localparam int NUM_REGS = 8;

    // major opcode, instr[15:11]
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_SIIC  = 5'b00010,
        OP_J     = 5'b00100,
        OP_ADDI  = 5'b01000,
        OP_SUBI  = 5'b01001,
        OP_XORI  = 5'b01010,
        OP_ANDNI = 5'b01011,
        OP_BEQZ  = 5'b01100,
        OP_BNEZ  = 5'b01101,
        OP_BLTZ  = 5'b01110,
        OP_BGEZ  = 5'b01111,
        OP_SLBI  = 5'b10010,
        OP_LBI   = 5'b11000,
        OP_ALU   = 5'b11011,   // add/sub/xor/andn by func
        OP_SEQ   = 5'b11100,
        OP_SLT   = 5'b11101,
        OP_SLE   = 5'b11110
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD        = 4'd0,
        ALU_SUB_REV    = 4'd1,   // b - a
        ALU_XOR        = 4'd2,
        ALU_ANDN       = 4'd3,   // a & ~b
        ALU_EQ         = 4'd4,
        ALU_LT         = 4'd5,   // signed
        ALU_LE         = 4'd6,   // signed
        ALU_PASS_B     = 4'd7,
        ALU_SHIFT_LOAD = 4'd8    // (a << 8) | b[7:0]
    } alu_op_e;

    typedef enum logic [1:0] {
        ZEXT5  = 2'd0,
        SEXT5  = 2'd1,
        SEXT8  = 2'd2,
        SEXT11 = 2'd3
    } imm_sel_e;

    typedef enum logic [1:0] {
        RD_I1 = 2'd0,   // instr[7:5]
        RD_R  = 2'd1,   // instr[4:2]
        RS    = 2'd2    // instr[10:8]
    } reg_dst_e;

    typedef struct packed {
        logic     reg_write;
        reg_dst_e reg_dst;
        imm_sel_e imm_sel;
        logic     alu_src_imm;
        alu_op_e  alu_op;
        logic     branch;
        logic     br_eqz;
        logic     br_gtz;
        logic     br_ltz;
        logic     jump;
        logic     halt;
        logic     err;
    } ctrl_t;

    // APB word address map, paddr[9:8] selects the region
    localparam logic [1:0] REGION_IMEM = 2'b00;
    localparam logic [1:0] REGION_CSR  = 2'b01;
    localparam logic [1:0] REGION_REGS = 2'b10;

    localparam logic [7:0] CSR_CTRL   = 8'd0;
    localparam logic [7:0] CSR_STATUS = 8'd1;
    localparam logic [7:0] CSR_PC     = 8'd2;

endpackage

/* hdl/wisc_top.sv */
`timescale 1ns/1ps

module wisc_top #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [9:0]                  paddr,
    input  logic [wisc_pkg::DATA_W-1:0] pwdata,
    output logic [wisc_pkg::DATA_W-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr
);
    import wisc_pkg::*;

    localparam int PC_W = $clog2(IMEM_DEPTH);

    logic [PC_W-1:0]             fetch_addr;
    logic [PC_W-1:0]             pc;
    logic [DATA_W-1:0]           instr;
    logic [DATA_W-1:0]           dbg_data;
    logic [$clog2(NUM_REGS)-1:0] dbg_addr;
    logic                        start;
    logic                        running;
    logic                        halted;
    logic                        error;
    opcode_e                     opcode;
    logic [1:0]                  func;
    ctrl_t                       ctrl;

    apb_prog_port #(.IMEM_DEPTH(IMEM_DEPTH)) u_apb (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .fetch_addr(fetch_addr), .instr(instr), .start(start),
        .dbg_addr(dbg_addr), .dbg_data(dbg_data),
        .running(running), .halted(halted), .error(error), .pc(pc)
    );

    instr_decoder u_dec (
        .opcode(opcode), .func(func), .ctrl(ctrl)
    );

    core_datapath #(.IMEM_DEPTH(IMEM_DEPTH)) u_core (
        .clk(clk), .arst_n(arst_n),
        .instr(instr), .start(start), .dbg_addr(dbg_addr), .ctrl(ctrl),
        .fetch_addr(fetch_addr), .opcode(opcode), .func(func), .dbg_data(dbg_data),
        .running(running), .halted(halted), .error(error), .pc(pc)
    );

endmodule

/* verif/tb_wisc.sv */
`timescale 1ns/1ps

module tb_wisc;
    import wisc_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int IMEM_DEPTH = 64;
    localparam int PC_W       = $clog2(IMEM_DEPTH);
    localparam int XFER_LIMIT = 8;
    localparam int POLL_LIMIT = 300;
    localparam int STEP_LIMIT = 1000;
    localparam int RAND_LEN   = 40;
    localparam logic [9:0] ADDR_CTRL   = {REGION_CSR, CSR_CTRL};
    localparam logic [9:0] ADDR_STATUS = {REGION_CSR, CSR_STATUS};
    localparam logic [9:0] ADDR_PC     = {REGION_CSR, CSR_PC};
    localparam logic [16:0][4:0] RAND_OPS = {OP_NOP, OP_SIIC, OP_ADDI, OP_SUBI, OP_XORI,
        OP_ANDNI, OP_ALU, OP_SEQ, OP_SLT, OP_SLE, OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ,
        OP_LBI, OP_SLBI, OP_J};

    typedef struct packed {
        logic [NUM_REGS-1:0][15:0] regs;
        logic [PC_W-1:0]           pc;
        logic [2:0]                status;   // error, halted, running
    } iss_res_t;

    logic        clk;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [9:0]  paddr;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [15:0] prog [IMEM_DEPTH];
    logic [NUM_REGS-1:0][15:0] model_regs;   // registers as the last run left them
    int          pidx;
    int          seed;
    int          k;
    int          r;
    int          case_num = 0;
    int          cases_bad = 0;
    int          prev_bad = 0;
    logic        hung = 1'b0;
    logic [4:0]  bop;

    wisc_top #(.IMEM_DEPTH(IMEM_DEPTH)) UUT (.*);

    wisc_checker u_checker (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    function automatic logic [15:0] imm_form(input logic [4:0] op, input int rs, input int rt,
                                             input int imm5);
        return {op, 3'(rs), 3'(rt), 5'(imm5)};
    endfunction

    function automatic logic [15:0] reg_form(input logic [4:0] op, input int rs, input int rt,
                                             input int rd, input int fn);
        return {op, 3'(rs), 3'(rt), 3'(rd), 2'(fn)};
    endfunction

    function automatic logic [15:0] byte_form(input logic [4:0] op, input int rs, input int imm8);
        return {op, 3'(rs), 8'(imm8)};
    endfunction

    function automatic logic [15:0] jump_form(input int disp);
        return {OP_J, 11'(disp)};
    endfunction

    // only forward targets up to the closing halt
    function automatic logic [15:0] random_instr(input int pos, input int len);
        logic [15:0] w;
        w = 16'($urandom);
        w[15:11] = RAND_OPS[$urandom % 17];
        if (w[15:13] == 3'b011)
            w[7:0] = 8'($urandom % (len - pos));
        else if (w[15:11] == OP_J)
            w[10:0] = 11'($urandom % (len - pos));
        return w;
    endfunction

    function automatic iss_res_t iss_run(input logic [NUM_REGS-1:0][15:0] init_regs);
        iss_res_t        res;
        logic [15:0]     w;
        logic [15:0]     a;
        logic [15:0]     b;
        logic [PC_W-1:0] next_pc;
        logic            stop;
        int              steps;
        res = '0;
        res.regs = init_regs;   // start leaves the register file alone
        stop = 1'b0;
        for (steps = 0; steps < STEP_LIMIT && !stop; steps++) begin
            w = prog[res.pc];
            a = res.regs[w[10:8]];
            b = res.regs[w[7:5]];
            next_pc = res.pc + 1'b1;
            case (w[15:11])
                OP_HALT: begin
                    res.status = 3'b010;
                    stop = 1'b1;
                end
                OP_NOP, OP_SIIC: ;
                OP_ADDI:  res.regs[w[7:5]] = a + {{11{w[4]}}, w[4:0]};
                OP_SUBI:  res.regs[w[7:5]] = {{11{w[4]}}, w[4:0]} - a;
                OP_XORI:  res.regs[w[7:5]] = a ^ {11'd0, w[4:0]};
                OP_ANDNI: res.regs[w[7:5]] = a & ~{11'd0, w[4:0]};
                OP_ALU: begin
                    case (w[1:0])
                        2'b00:   res.regs[w[4:2]] = a + b;
                        2'b01:   res.regs[w[4:2]] = b - a;
                        2'b10:   res.regs[w[4:2]] = a ^ b;
                        default: res.regs[w[4:2]] = a & ~b;
                    endcase
                end
                OP_SEQ: res.regs[w[4:2]] = {15'd0, a == b};
                OP_SLT: res.regs[w[4:2]] = {15'd0, $signed(a) < $signed(b)};
                OP_SLE: res.regs[w[4:2]] = {15'd0, $signed(a) <= $signed(b)};
                OP_BEQZ: if (a == 16'd0) next_pc = PC_W'(next_pc + {{8{w[7]}}, w[7:0]});
                OP_BNEZ: if (a != 16'd0) next_pc = PC_W'(next_pc + {{8{w[7]}}, w[7:0]});
                OP_BLTZ: if (a[15]) next_pc = PC_W'(next_pc + {{8{w[7]}}, w[7:0]});
                OP_BGEZ: if (!a[15]) next_pc = PC_W'(next_pc + {{8{w[7]}}, w[7:0]});
                OP_LBI:  res.regs[w[10:8]] = {{8{w[7]}}, w[7:0]};
                OP_SLBI: res.regs[w[10:8]] = {a[7:0], w[7:0]};
                OP_J:    next_pc = PC_W'(next_pc + {{5{w[10]}}, w[10:0]});
                default: begin
                    res.status = 3'b100;   // unimplemented, pc stays
                    stop = 1'b1;
                end
            endcase
            if (!stop)
                res.pc = next_pc;
        end
        if (!stop)
            res.status = 3'b001;
        return res;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [9:0] addr, input logic [15:0] wdata,
                            output logic [15:0] rdata);
        int   waits;
        logic done;
        rdata = '0;
        done = 1'b0;
        waits = 0;
        if (hung)
            return;
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        while (!done && waits < XFER_LIMIT) begin
            @(posedge clk);
            done = pready;
            rdata = prdata;
            waits++;
        end
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        if (!done) begin
            $display("APB transfer to 0x%h never completed, pready stayed low", addr);
            hung = 1'b1;
        end
    endtask

    task automatic write_word(input logic [9:0] addr, input logic [15:0] data, input logic err);
        logic [15:0] unused;
        u_checker.expect_xfer(16'h0, err, 1'b0, 1'b0);
        apb_xfer(1'b1, addr, data, unused);
    endtask

    // csr and register reads are registered, one wait state
    task automatic read_expect(input logic [9:0] addr, input logic [15:0] exp, input logic err);
        logic [15:0] unused;
        u_checker.expect_xfer(exp, err, 1'b1, !err && (addr[9:8] != REGION_IMEM));
        apb_xfer(1'b0, addr, 16'h0, unused);
    endtask

    task automatic read_raw(input logic [9:0] addr, output logic [15:0] data);
        u_checker.expect_xfer(16'h0, 1'b0, 1'b0, addr[9:8] != REGION_IMEM);
        apb_xfer(1'b0, addr, 16'h0, data);
    endtask

    task automatic clear_prog();
        for (int a = 0; a < IMEM_DEPTH; a++)
            prog[a] = 16'h0000;   // halt
        pidx = 0;
    endtask

    task automatic emit(input logic [15:0] w);
        prog[pidx] = w;
        pidx++;
    endtask

    task automatic load_and_start();
        for (int a = 0; a < IMEM_DEPTH; a++)
            write_word(10'(a), prog[a], 1'b0);
        write_word(ADDR_CTRL, 16'h0001, 1'b0);
    endtask

    task automatic wait_done();
        logic [15:0] st;
        int          polls;
        st = '0;
        polls = 0;
        while (!(st[1] | st[2]) && polls < POLL_LIMIT && !hung) begin
            read_raw(ADDR_STATUS, st);
            polls++;
        end
        if (!(st[1] | st[2]) && !hung) begin
            $display("core neither halted nor flagged an error after %0d polls", POLL_LIMIT);
            hung = 1'b1;
        end
    endtask

    task automatic check_result();
        iss_res_t exp;
        exp = iss_run(model_regs);
        model_regs = exp.regs;
        read_expect(ADDR_STATUS, {13'd0, exp.status}, 1'b0);
        read_expect(ADDR_PC, 16'(exp.pc), 1'b0);
        for (int n = 0; n < NUM_REGS; n++)
            read_expect({REGION_REGS, 8'(n)}, exp.regs[n], 1'b0);
    endtask

    task automatic run_and_check();
        load_and_start();
        wait_done();
        check_result();
    endtask

    task automatic end_case(input string name);
        int total;
        total = u_checker.errors + int'(hung);
        case_num++;
        if (total == prev_bad) begin
            $display("case %0d %s: ok", case_num, name);
        end else begin
            cases_bad++;
            $display("case %0d %s: %0d problem(s)", case_num, name, total - prev_bad);
        end
        prev_bad = total;
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        model_regs = '0;
        seed = 43154;
        seed = $urandom(seed);
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        read_expect(ADDR_STATUS, 16'h0, 1'b0);
        read_expect(ADDR_PC, 16'h0, 1'b0);
        for (int n = 0; n < NUM_REGS; n++)
            read_expect({REGION_REGS, 8'(n)}, 16'h0, 1'b0);
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            prog[a] = 16'($urandom);
            write_word(10'(a), prog[a], 1'b0);
        end
        for (int a = 0; a < IMEM_DEPTH; a++)
            read_expect(10'(a), prog[a], 1'b0);
        end_case("reset state and imem readback");

        clear_prog();
        emit(byte_form(OP_LBI, 1, 8'h12));
        emit(byte_form(OP_SLBI, 1, 8'h34));
        emit(byte_form(OP_LBI, 2, -3));
        emit(imm_form(OP_ADDI, 1, 3, -7));
        emit(imm_form(OP_SUBI, 2, 4, 9));
        emit(imm_form(OP_XORI, 1, 5, 5'h1f));
        emit(imm_form(OP_ANDNI, 1, 6, 5'h0f));
        emit(imm_form(OP_ADDI, 2, 7, 15));
        emit(byte_form(OP_LBI, 0, 8'h80));
        run_and_check();
        clear_prog();
        emit(byte_form(OP_LBI, 1, 8'h70));
        emit(byte_form(OP_SLBI, 1, 8'h0f));
        emit(byte_form(OP_LBI, 2, -100));
        emit(reg_form(OP_ALU, 1, 2, 3, 0));
        emit(reg_form(OP_ALU, 1, 2, 4, 1));
        emit(reg_form(OP_ALU, 1, 2, 5, 2));
        emit(reg_form(OP_ALU, 1, 2, 6, 3));
        emit(reg_form(OP_SEQ, 1, 2, 7, 0));
        emit(reg_form(OP_SLT, 2, 1, 0, 0));
        emit(reg_form(OP_SLE, 2, 2, 1, 0));
        run_and_check();
        end_case("immediate, alu and set instructions");

        clear_prog();
        emit(byte_form(OP_LBI, 1, -5));
        emit(byte_form(OP_LBI, 2, 0));
        emit(byte_form(OP_LBI, 3, 7));
        for (k = 0; k < 4; k++) begin
            for (r = 1; r <= 3; r++) begin
                bop = OP_BEQZ;
                bop = bop + 5'(k);
                emit(reg_form(OP_ALU, 4, 4, 4, 0));   // r4 doubles, one bit per case
                emit(byte_form(bop, r, 1));
                emit(imm_form(OP_ADDI, 4, 4, 1));
            end
        end
        emit(jump_form(1));
        emit(imm_form(OP_ADDI, 6, 6, 1));
        emit(jump_form(2));
        emit(imm_form(OP_ADDI, 7, 7, 3));
        emit(jump_form(2));
        emit(jump_form(-3));   // back to the r7 update
        emit(imm_form(OP_ADDI, 6, 6, 5));
        run_and_check();
        end_case("branches and jumps");

        clear_prog();
        emit(byte_form(OP_LBI, 1, 8'h55));
        emit(imm_form(OP_ADDI, 1, 2, 1));
        emit(imm_form(5'b10001, 1, 3, 0));   // load, not implemented
        emit(byte_form(OP_LBI, 3, 9));
        run_and_check();
        end_case("unimplemented opcode");

        clear_prog();
        emit(byte_form(OP_LBI, 1, 60));
        emit(imm_form(OP_ADDI, 1, 1, -1));
        emit(byte_form(OP_BNEZ, 1, -2));
        load_and_start();
        write_word(10'd10, 16'hbeef, 1'b1);
        write_word(ADDR_STATUS, 16'h0007, 1'b1);
        read_expect(10'h305, 16'h0, 1'b1);
        write_word(10'h300, 16'h1234, 1'b1);
        wait_done();
        check_result();
        read_expect(10'd10, prog[10], 1'b0);
        end_case("APB error responses");

        for (int p = 0; p < 20; p++) begin
            clear_prog();
            for (int i = 0; i < RAND_LEN; i++)
                prog[i] = random_instr(i, RAND_LEN);
            run_and_check();
        end
        end_case("random programs");

        $display("cases %0d, with problems %0d, checks %0d, mismatches %0d, assertion fails %0d",
                 case_num, cases_bad, u_checker.checks, u_checker.errors,
                 UUT.u_sva.fail_count);
        if (cases_bad == 0 && !hung && u_checker.errors == 0 && UUT.u_sva.fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* verif/wisc_checker.sv */
`timescale 1ns/1ps

module wisc_checker (
    input logic        clk,
    input logic        arst_n,
    input logic        psel,
    input logic        penable,
    input logic        pwrite,
    input logic [9:0]  paddr,
    input logic [15:0] prdata,
    input logic        pready,
    input logic        pslverr
);
    typedef struct packed {
        logic [15:0] data;
        logic        err;
        logic        cmp;    // compare read data
        logic        slow;   // one wait state expected
    } expect_t;

    expect_t     exp_q[$];
    expect_t     cur;
    int unsigned checks = 0;
    int unsigned errors = 0;
    int unsigned wait_cycles = 0;

    task automatic expect_xfer(input logic [15:0] data, input logic err, input logic cmp,
                               input logic slow);
        exp_q.push_back({data, err, cmp, slow});
    endtask

    always @(posedge clk) begin
        if (!(arst_n && psel && penable)) begin
            wait_cycles = 0;
        end else if (!pready) begin
            wait_cycles++;
        end else begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("APB transfer to 0x%h at %0d ns was not announced", paddr, $time);
            end else begin
                cur = exp_q.pop_front();
                checks++;
                if (pslverr !== cur.err) begin
                    errors++;
                    $display("error at %0d ns: pslverr %b at 0x%h, expected %b",
                             $time, pslverr, paddr, cur.err);
                end else if (wait_cycles != cur.slow) begin
                    errors++;
                    $display("error at %0d ns: %0d wait state(s) at 0x%h, expected %0d",
                             $time, wait_cycles, paddr, cur.slow);
                end else if (cur.cmp && !pwrite && !cur.err && prdata !== cur.data) begin
                    errors++;
                    $display("error at %0d ns: read 0x%h returned 0x%h, expected 0x%h",
                             $time, paddr, prdata, cur.data);
                end
            end
            wait_cycles = 0;
        end
    end

endmodule

/* verif/wisc_sva.sv */
`timescale 1ns/1ps

module wisc_sva #(
    parameter int PC_W = 6
) (
    input logic            clk,
    input logic            arst_n,
    input logic            psel,
    input logic            penable,
    input logic            start,
    input logic            running,
    input logic            halted,
    input logic [PC_W-1:0] pc
);
    int unsigned fail_count = 0;

    enable_after_setup: assert property (@(posedge clk) disable iff (!arst_n)
        (psel && !penable) |=> (psel && penable))
        else begin
            $error("penable did not follow the setup phase");
            fail_count++;
        end

    enable_needs_select: assert property (@(posedge clk) disable iff (!arst_n)
        penable |-> psel)
        else begin
            $error("penable high without psel");
            fail_count++;
        end

    start_single_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        start |=> !start)
        else begin
            $error("start pulse longer than one cycle");
            fail_count++;
        end

    run_halt_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !(running && halted))
        else begin
            $error("running and halted both set");
            fail_count++;
        end

    pc_held_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
        (!running && !start) |=> $stable(pc))
        else begin
            $error("pc moved while the core was idle");
            fail_count++;
        end

endmodule

bind wisc_top wisc_sva #(.PC_W($clog2(IMEM_DEPTH))) u_sva (
    .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable),
    .start(start), .running(running), .halted(halted), .pc(pc)
);
